//--- elink_adapter.sv
`timescale 1ns/1ps

module elink_adapter #(
	parameter int INPUT_WIDTH  = 32,
	parameter int OUTPUT_WIDTH = 8
) (
	input  logic                    clk160,
	input  logic                    arst_n,
	input  logic [INPUT_WIDTH-1:0]  s_data,
	input  logic                    s_valid,
	output logic                    s_ready,
	output logic [OUTPUT_WIDTH-1:0] m_data,
	output logic                    m_valid,
	input  logic                    m_ready
);

	import elink_link_pkg::*;

	generate
	if ((INPUT_WIDTH == 32) && (OUTPUT_WIDTH == 8)) begin : g_down
		adapter_state_e state_q;
		adapter_state_e state_d;
		logic [31:0]    word_q;
		logic [31:0]    word_d;

		always_comb begin
			state_d = state_q;
			word_d  = word_q;
			s_ready = 1'b0;
			m_valid = 1'b1;
			m_data  = word_q[31:24];
			case (state_q)
				WAIT: begin
					s_ready = 1'b1;
					m_valid = 1'b0;
					if (s_valid) begin
						word_d  = s_data;
						state_d = BYTE0;
					end
				end
				BYTE0: begin
					if (m_ready) begin
						state_d = BYTE1;
					end
				end
				BYTE1: begin
					m_data = word_q[23:16];
					if (m_ready) begin
						state_d = BYTE2;
					end
				end
				BYTE2: begin
					m_data = word_q[15:8];
					if (m_ready) begin
						state_d = BYTE3;
					end
				end
				BYTE3: begin
					// next word may load as the last byte leaves
					m_data  = word_q[7:0];
					s_ready = m_ready;
					if (m_ready) begin
						if (s_valid) begin
							word_d  = s_data;
							state_d = BYTE0;
						end else begin
							state_d = WAIT;
						end
					end
				end
				default: begin
					m_valid = 1'b0;
					state_d = WAIT;
				end
			endcase
		end

		always_ff @(posedge clk160 or negedge arst_n) begin
			if (!arst_n) begin
				state_q <= WAIT;
			end else begin
				state_q <= state_d;
			end
		end

		always_ff @(posedge clk160) begin
			word_q <= word_d;
		end
	end else if ((INPUT_WIDTH == 8) && (OUTPUT_WIDTH == 32)) begin : g_up
		adapter_state_e state_q;
		adapter_state_e state_d;
		logic [31:0]    word_q;
		logic [31:0]    word_d;

		// first byte lands in the top of the word
		always_comb begin
			state_d = state_q;
			word_d  = word_q;
			s_ready = 1'b1;
			m_valid = 1'b0;
			m_data  = word_q;
			case (state_q)
				BYTE0: begin
					if (s_valid) begin
						word_d[31:24] = s_data;
						state_d       = BYTE1;
					end
				end
				BYTE1: begin
					if (s_valid) begin
						word_d[23:16] = s_data;
						state_d       = BYTE2;
					end
				end
				BYTE2: begin
					if (s_valid) begin
						word_d[15:8] = s_data;
						state_d      = BYTE3;
					end
				end
				BYTE3: begin
					if (s_valid) begin
						word_d[7:0] = s_data;
						state_d     = WAIT;
					end
				end
				WAIT: begin
					s_ready = 1'b0;
					m_valid = 1'b1;
					if (m_ready) begin
						state_d = BYTE0;
					end
				end
				default: begin
					s_ready = 1'b0;
					state_d = BYTE0;
				end
			endcase
		end

		always_ff @(posedge clk160 or negedge arst_n) begin
			if (!arst_n) begin
				state_q <= BYTE0;
			end else begin
				state_q <= state_d;
			end
		end

		always_ff @(posedge clk160) begin
			word_q <= word_d;
		end
	end
	endgenerate

	a_hold_data: assert property (@(posedge clk160) disable iff (!arst_n)
		m_valid && !m_ready |=> m_valid && $stable(m_data));

endmodule

//--- elink_apb_regs.sv
`timescale 1ns/1ps

module elink_apb_regs #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic                         clk160,
	input  logic                         arst_n,
	input  elink_host_pkg::apb_req_t     apb_req,
	output elink_host_pkg::apb_rsp_t     apb_rsp,
	output elink_host_pkg::ctrl_t        ctrl,
	output elink_link_pkg::word_stream_t tx_push,
	input  logic                         tx_ready,
	input  elink_link_pkg::word_stream_t rx_word,
	output logic                         rx_pop,
	input  logic [4:0]                   tx_level,
	input  logic [4:0]                   rx_level,
	input  logic                         framing_error,
	input  logic                         overrun
);

	import elink_host_pkg::*;

	ctrl_t       ctrl_q;
	status_t     status;
	reg_addr_e   addr;
	logic        access;
	logic        known;
	logic        wr_ctrl;
	logic        wr_tx;
	logic        rd_rx;
	logic        ferr_q;
	logic        ovr_q;
	logic [31:0] rdata;

	assign access  = apb_req.psel && apb_req.penable;
	assign addr    = reg_addr_e'(apb_req.paddr);
	assign wr_ctrl = access && apb_req.pwrite && (addr == REG_CTRL);
	assign wr_tx   = access && apb_req.pwrite && (addr == REG_TX_DATA);
	assign rd_rx   = access && !apb_req.pwrite && (addr == REG_RX_DATA);

	assign status.tx_level      = tx_level;
	assign status.rx_level      = rx_level;
	assign status.framing_error = ferr_q;
	assign status.rx_overrun    = ovr_q;

	always_comb begin
		known = 1'b1;
		rdata = '0;
		case (addr)
			REG_CTRL:    rdata = {31'b0, ctrl_q.tx_enable};
			REG_STATUS:  rdata = {20'b0, status};
			REG_TX_DATA: rdata = '0;
			REG_RX_DATA: rdata = rx_word.data;
			default:     known = 1'b0;
		endcase
	end

	// push and pop happen at the edge that ends the access cycle
	assign tx_push.valid = wr_tx && tx_ready;
	assign tx_push.data  = apb_req.pwdata;
	assign rx_pop        = rd_rx && rx_word.valid;

	assign apb_rsp.prdata  = rdata;
	assign apb_rsp.pready  = 1'b1;
	assign apb_rsp.pslverr = access &&
		(!known || (wr_tx && !tx_ready) || (rd_rx && !rx_word.valid));

	assign ctrl = ctrl_q;

	always_ff @(posedge clk160 or negedge arst_n) begin
		if (!arst_n) begin
			ctrl_q <= '0;
			ferr_q <= 1'b0;
			ovr_q  <= 1'b0;
		end else begin
			if (wr_ctrl) begin
				ctrl_q.tx_enable   <= apb_req.pwdata[0];
				ctrl_q.clear_flags <= apb_req.pwdata[1];
			end else begin
				ctrl_q.clear_flags <= 1'b0;
			end
			// sticky until cleared
			ferr_q <= (ferr_q && !ctrl_q.clear_flags) || framing_error;
			ovr_q  <= (ovr_q && !ctrl_q.clear_flags) || overrun;
		end
	end

	a_level_range: assert property (@(posedge clk160) disable iff (!arst_n)
		(tx_level <= FIFO_DEPTH) && (rx_level <= FIFO_DEPTH));

endmodule

//--- elink_deserializer.sv
`timescale 1ns/1ps

module elink_deserializer (
	input  logic                         clk160,
	input  logic                         arst_n,
	input  logic                         line,
	output elink_link_pkg::byte_stream_t m_byte,
	input  logic                         m_ready,
	output logic                         framing_error,
	output logic                         overrun
);

	import elink_link_pkg::*;

	des_state_e state_q;
	logic       line_q;
	logic [7:0] shift_q;
	logic [2:0] bit_cnt;
	logic       valid_q;
	logic       ferr_q;

	assign m_byte.data   = shift_q;
	assign m_byte.valid  = valid_q;
	assign framing_error = ferr_q;
	// line cannot stall, an unaccepted byte is gone
	assign overrun       = valid_q && !m_ready;

	always_ff @(posedge clk160 or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= DES_HUNT;
			line_q  <= 1'b1;
			bit_cnt <= '0;
			valid_q <= 1'b0;
			ferr_q  <= 1'b0;
		end else begin
			line_q  <= line;
			valid_q <= 1'b0;
			ferr_q  <= 1'b0;
			case (state_q)
				DES_HUNT: begin
					if (line_q && !line) begin
						state_q <= DES_DATA;
						bit_cnt <= '0;
					end
				end
				DES_DATA: begin
					bit_cnt <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7) begin
						state_q <= DES_STOP;
					end
				end
				DES_STOP: begin
					state_q <= DES_HUNT;
					if (line) begin
						valid_q <= 1'b1;
					end else begin
						ferr_q <= 1'b1;
					end
				end
				default: state_q <= DES_HUNT;
			endcase
		end
	end

	always_ff @(posedge clk160) begin
		if (state_q == DES_DATA) begin
			shift_q <= {shift_q[6:0], line};
		end
	end

endmodule

//--- elink_host_pkg.sv
package elink_host_pkg;

	// register offsets on the host port
	typedef enum logic [3:0] {
		REG_CTRL    = 4'h0,
		REG_STATUS  = 4'h4,
		REG_TX_DATA = 4'h8,
		REG_RX_DATA = 4'hC
	} reg_addr_e;

	// bit 0 tx_enable, bit 1 clear_flags
	typedef struct packed {
		logic clear_flags;
		logic tx_enable;
	} ctrl_t;

	// read as the low 12 bits of STATUS
	typedef struct packed {
		logic [4:0] tx_level;
		logic [4:0] rx_level;
		logic       framing_error;
		logic       rx_overrun;
	} status_t;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [3:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

endpackage

//--- elink_link_pkg.sv
package elink_link_pkg;

	// ready travels as a separate signal
	typedef struct packed {
		logic [31:0] data;
		logic        valid;
	} word_stream_t;

	typedef struct packed {
		logic [7:0] data;
		logic       valid;
	} byte_stream_t;

	// WAIT holds a full word, BYTEn is the byte in flight
	typedef enum logic [2:0] {
		WAIT,
		BYTE0,
		BYTE1,
		BYTE2,
		BYTE3
	} adapter_state_e;

	typedef enum logic [1:0] {
		SER_IDLE,
		SER_START,
		SER_DATA,
		SER_STOP
	} ser_state_e;

	typedef enum logic [1:0] {
		DES_HUNT,
		DES_DATA,
		DES_STOP
	} des_state_e;

endpackage

//--- elink_serializer.sv
`timescale 1ns/1ps

module elink_serializer (
	input  logic                         clk160,
	input  logic                         arst_n,
	input  logic                         enable,
	input  elink_link_pkg::byte_stream_t s_byte,
	output logic                         s_ready,
	output logic                         line
);

	import elink_link_pkg::*;

	ser_state_e state_q;
	logic [7:0] shift_q;
	logic [2:0] bit_cnt;
	logic       take;

	// stop bit is a single cycle, so a new byte can follow it directly
	assign s_ready = enable && ((state_q == SER_IDLE) || (state_q == SER_STOP));
	assign take    = s_ready && s_byte.valid;

	always_comb begin
		case (state_q)
			SER_START: line = 1'b0;
			SER_DATA:  line = shift_q[7];
			default:   line = 1'b1;
		endcase
	end

	always_ff @(posedge clk160 or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= SER_IDLE;
			bit_cnt <= '0;
		end else begin
			case (state_q)
				SER_IDLE, SER_STOP: begin
					state_q <= take ? SER_START : SER_IDLE;
				end
				SER_START: begin
					state_q <= SER_DATA;
					bit_cnt <= '0;
				end
				SER_DATA: begin
					bit_cnt <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7) begin
						state_q <= SER_STOP;
					end
				end
				default: state_q <= SER_IDLE;
			endcase
		end
	end

	// msb first
	always_ff @(posedge clk160) begin
		if (take) begin
			shift_q <= s_byte.data;
		end else if (state_q == SER_DATA) begin
			shift_q <= {shift_q[6:0], 1'b0};
		end
	end

	// the line only idles after a high stop bit
	a_idle_high: assert property (@(posedge clk160) disable iff (!arst_n)
		state_q == SER_IDLE |-> line && $past(line));

	// stop bit nine cycles after the start bit
	a_stop_bit: assert property (@(posedge clk160) disable iff (!arst_n)
		state_q == SER_START |-> ##9 line);

endmodule

//--- elink_stimulus.txt
# command offset operand expected: WRITE off data pslverr, READ off data pslverr,
# POLL off mask value, all hex; BREAK cycles and IDLE cycles in decimal
READ 4 00000000 0
READ c 00000000 1
WRITE 0 00000001 0
READ 0 00000001 0
WRITE 8 a5c30f96 0
POLL 4 0000007c 00000004
READ c a5c30f96 0
WRITE 8 12345678 0
WRITE 8 9abcdef0 0
WRITE 8 00ff00ff 0
POLL 4 0000007c 0000000c
READ c 12345678 0
READ c 9abcdef0 0
READ c 00ff00ff 0
WRITE 0 00000000 0
WRITE 8 0badf00d 0
WRITE 8 13572468 0
WRITE 8 c0ffee01 0
WRITE 8 7e57da7a 0
WRITE 8 5a5a0ff0 0
WRITE 8 8badbeef 1
READ 4 00000200 0
WRITE 0 00000001 0
POLL 4 0000007c 00000010
READ c 0badf00d 0
READ c 13572468 0
READ c c0ffee01 0
READ c 7e57da7a 0
POLL 4 0000007c 00000004
READ c 5a5a0ff0 0
READ 4 00000000 0
BREAK 20
READ 4 00000002 0
WRITE 0 00000003 0
READ 4 00000000 0
READ 0 00000001 0
WRITE 8 3c3c9669 0
POLL 4 0000007c 00000004
READ c 3c3c9669 0
WRITE 8 6a6b6c6d 0
WRITE 8 0f1e2d3c 0
WRITE 8 4b5a6978 0
IDLE 100
WRITE 8 8796a5b4 0
WRITE 8 c3d2e1f0 0
WRITE 8 fedcba98 0
POLL 4 00000001 00000001
IDLE 60
READ c 6a6b6c6d 0
READ c 0f1e2d3c 0
READ c 4b5a6978 0
READ c 8796a5b4 0
READ c c3d2e1f0 0
READ 4 00000001 0
WRITE 2 deadbeef 1
READ 6 00000000 1
WRITE e 00000000 1
READ 4 00000001 0
READ 0 00000001 0

//--- elink_top.sv
`timescale 1ns/1ps

module elink_top #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic                     clk160,
	input  logic                     arst_n,
	input  elink_host_pkg::apb_req_t apb_req,
	output elink_host_pkg::apb_rsp_t apb_rsp,
	output logic                     elink_tx,
	input  logic                     elink_rx
);

	import elink_host_pkg::*;
	import elink_link_pkg::*;

	ctrl_t        ctrl;
	word_stream_t tx_push;
	word_stream_t tx_word;
	word_stream_t rx_word_in;
	word_stream_t rx_word;
	byte_stream_t tx_byte;
	byte_stream_t rx_byte;
	logic         tx_push_ready;
	logic         tx_word_ready;
	logic         tx_byte_ready;
	logic         rx_byte_ready;
	logic         rx_word_in_ready;
	logic         rx_pop;
	logic [4:0]   tx_level;
	logic [4:0]   rx_level;
	logic         framing_error;
	logic         overrun;

	elink_apb_regs #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_regs (
		.clk160        (clk160),
		.arst_n        (arst_n),
		.apb_req       (apb_req),
		.apb_rsp       (apb_rsp),
		.ctrl          (ctrl),
		.tx_push       (tx_push),
		.tx_ready      (tx_push_ready),
		.rx_word       (rx_word),
		.rx_pop        (rx_pop),
		.tx_level      (tx_level),
		.rx_level      (rx_level),
		.framing_error (framing_error),
		.overrun       (overrun)
	);

	// transmit path
	elink_word_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_tx_fifo (
		.clk160    (clk160),
		.arst_n    (arst_n),
		.in_word   (tx_push),
		.in_ready  (tx_push_ready),
		.out_word  (tx_word),
		.out_ready (tx_word_ready),
		.level     (tx_level)
	);

	elink_adapter #(
		.INPUT_WIDTH  (32),
		.OUTPUT_WIDTH (8)
	) u_tx_adapter (
		.clk160  (clk160),
		.arst_n  (arst_n),
		.s_data  (tx_word.data),
		.s_valid (tx_word.valid),
		.s_ready (tx_word_ready),
		.m_data  (tx_byte.data),
		.m_valid (tx_byte.valid),
		.m_ready (tx_byte_ready)
	);

	elink_serializer u_serializer (
		.clk160  (clk160),
		.arst_n  (arst_n),
		.enable  (ctrl.tx_enable),
		.s_byte  (tx_byte),
		.s_ready (tx_byte_ready),
		.line    (elink_tx)
	);

	// receive path
	elink_deserializer u_deserializer (
		.clk160        (clk160),
		.arst_n        (arst_n),
		.line          (elink_rx),
		.m_byte        (rx_byte),
		.m_ready       (rx_byte_ready),
		.framing_error (framing_error),
		.overrun       (overrun)
	);

	elink_adapter #(
		.INPUT_WIDTH  (8),
		.OUTPUT_WIDTH (32)
	) u_rx_adapter (
		.clk160  (clk160),
		.arst_n  (arst_n),
		.s_data  (rx_byte.data),
		.s_valid (rx_byte.valid),
		.s_ready (rx_byte_ready),
		.m_data  (rx_word_in.data),
		.m_valid (rx_word_in.valid),
		.m_ready (rx_word_in_ready)
	);

	elink_word_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_rx_fifo (
		.clk160    (clk160),
		.arst_n    (arst_n),
		.in_word   (rx_word_in),
		.in_ready  (rx_word_in_ready),
		.out_word  (rx_word),
		.out_ready (rx_pop),
		.level     (rx_level)
	);

endmodule

//--- elink_word_fifo.sv
`timescale 1ns/1ps

module elink_word_fifo #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic                         clk160,
	input  logic                         arst_n,
	input  elink_link_pkg::word_stream_t in_word,
	output logic                         in_ready,
	output elink_link_pkg::word_stream_t out_word,
	input  logic                         out_ready,
	output logic [4:0]                   level
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

	logic [31:0]      mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [4:0]       count;
	logic             push;
	logic             pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		// depth need not be a power of two
		if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign in_ready       = (count != 5'(FIFO_DEPTH));
	assign push           = in_word.valid && in_ready;
	assign pop            = out_word.valid && out_ready;
	assign out_word.valid = (count != '0);
	assign out_word.data  = mem[rd_ptr];
	assign level          = count;

	always_ff @(posedge clk160 or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			count <= count + 5'(push) - 5'(pop);
		end
	end

	always_ff @(posedge clk160) begin
		if (push) begin
			mem[wr_ptr] <= in_word.data;
		end
	end

	a_count_range: assert property (@(posedge clk160) disable iff (!arst_n)
		count <= FIFO_DEPTH);

	// head word must not change while the consumer stalls
	a_head_stable: assert property (@(posedge clk160) disable iff (!arst_n)
		out_word.valid && !out_ready |=> out_word.valid && $stable(out_word.data));

endmodule

//--- sim.f
elink_host_pkg.sv
elink_link_pkg.sv
elink_word_fifo.sv
elink_adapter.sv
elink_serializer.sv
elink_deserializer.sv
elink_apb_regs.sv
elink_top.sv
tb_elink_top.sv

//--- tb_elink_top.sv
`timescale 1ns/1ps

module tb_elink_top;

	import elink_host_pkg::*;

	// small FIFOs keep the fill and overflow cases short
	localparam int FIFO_DEPTH         = 4;
	localparam int CLK_PERIOD         = 8;
	localparam int RESET_CYCLES       = 16;
	localparam int CYCLES_PER_COMMAND = 60;

	logic     clk160;
	logic     arst_n;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	logic     elink_tx;
	logic     elink_rx;
	logic     break_active;

	string       cmd_op[$];
	logic [31:0] cmd_a[$];
	logic [31:0] cmd_b[$];
	logic [31:0] cmd_c[$];
	int          cycle_count;
	int          cycle_limit;

	elink_top #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) dut (
		.clk160   (clk160),
		.arst_n   (arst_n),
		.apb_req  (apb_req),
		.apb_rsp  (apb_rsp),
		.elink_tx (elink_tx),
		.elink_rx (elink_rx)
	);

	// serial loopback, a break pulls the line low
	assign elink_rx = elink_tx && !break_active;

	initial begin
		clk160 = 1'b0;
		forever #(CLK_PERIOD / 2) clk160 = ~clk160;
	end

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_value(input string what, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			stop_with_failure($sformatf("error at %0t ns: %s is %08h, expected %08h",
				$time, what, actual, expected));
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clk160);
			#1;
		end
	endtask

	// starts 1 ns after an edge and returns 1 ns after the closing edge
	task automatic apb_access(input logic write, input logic [3:0] offset,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = write;
		apb_req.paddr   = offset;
		apb_req.pwdata  = wdata;
		@(posedge clk160);
		#1;
		apb_req.penable = 1'b1;
		// sample mid-cycle, well away from the edge
		#(CLK_PERIOD / 2 - 1);
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
		check_value("pready", 32'(apb_rsp.pready), 32'd1);
		@(posedge clk160);
		#1;
		apb_req = '0;
	endtask

	task automatic poll_register(input logic [3:0] offset, input logic [31:0] mask,
		input logic [31:0] value);
		logic [31:0] rdata;
		logic        err;
		bit          matched;
		matched = 1'b0;
		while (!matched) begin
			apb_access(1'b0, offset, '0, rdata, err);
			check_value($sformatf("pslverr polling offset %h", offset), 32'(err), '0);
			matched = ((rdata & mask) === value);
		end
	endtask

	task automatic load_commands();
		int          fd;
		int          n;
		int          cycles_total;
		string       line;
		string       op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		fd = $fopen("elink_stimulus.txt", "r");
		if (fd == 0) begin
			stop_with_failure("cannot open elink_stimulus.txt for reading");
		end
		cycles_total = RESET_CYCLES;
		while ($fgets(line, fd) > 0) begin
			if ((line.len() == 0) || (line.getc(0) == "#")) begin
				continue;
			end
			n = $sscanf(line, "%s", op);
			if (n != 1) begin
				continue;
			end
			a = '0;
			b = '0;
			c = '0;
			if ((op == "IDLE") || (op == "BREAK")) begin
				n = $sscanf(line, "%s %d", op, a);
				cycles_total += a;
				if (n != 2) begin
					stop_with_failure($sformatf("malformed stimulus line: %s", line));
				end
			end else begin
				n = $sscanf(line, "%s %h %h %h", op, a, b, c);
				if (n != 4) begin
					stop_with_failure($sformatf("malformed stimulus line: %s", line));
				end
			end
			cmd_op.push_back(op);
			cmd_a.push_back(a);
			cmd_b.push_back(b);
			cmd_c.push_back(c);
			cycles_total += CYCLES_PER_COMMAND;
		end
		$fclose(fd);
		cycle_limit = cycles_total;
	endtask

	task automatic run_command(input int idx);
		string       op;
		logic [31:0] rdata;
		logic        err;
		op = cmd_op[idx];
		if (op == "WRITE") begin
			apb_access(1'b1, cmd_a[idx][3:0], cmd_b[idx], rdata, err);
			check_value($sformatf("pslverr of write %0d", idx), 32'(err), cmd_c[idx]);
		end else if (op == "READ") begin
			apb_access(1'b0, cmd_a[idx][3:0], '0, rdata, err);
			check_value($sformatf("pslverr of read %0d", idx), 32'(err), cmd_c[idx]);
			// error responses carry no data
			if (cmd_c[idx] == 0) begin
				check_value($sformatf("data of read %0d", idx), rdata, cmd_b[idx]);
			end
		end else if (op == "POLL") begin
			poll_register(cmd_a[idx][3:0], cmd_b[idx], cmd_c[idx]);
		end else if (op == "BREAK") begin
			break_active = 1'b1;
			wait_cycles(cmd_a[idx]);
			break_active = 1'b0;
		end else if (op == "IDLE") begin
			wait_cycles(cmd_a[idx]);
		end else begin
			stop_with_failure($sformatf("unknown command %s in stimulus file", op));
		end
	endtask

	always @(posedge clk160) begin
		cycle_count = cycle_count + 1;
		if ((cycle_limit > 0) && (cycle_count > cycle_limit)) begin
			stop_with_failure($sformatf("timeout: test still running after %0d cycles",
				cycle_limit));
		end
	end

	initial begin
		int gap;
		void'($urandom(32'h75c0_230a));
		apb_req      = '0;
		arst_n       = 1'b0;
		break_active = 1'b0;
		cycle_count  = 0;
		cycle_limit  = 0;
		load_commands();
		repeat (RESET_CYCLES) @(posedge clk160);
		#1;
		arst_n = 1'b1;
		wait_cycles(2);
		// serial line idles high
		check_value("elink_tx after reset", 32'(elink_tx), 32'd1);
		for (int i = 0; i < cmd_op.size(); i++) begin
			run_command(i);
			gap = $urandom_range(3, 0);
			wait_cycles(gap);
		end
		$display("Done: no errors");
		$finish;
	end

endmodule
